//--- Makefile
# Verilator build and run for the JTAG user register testbench

VERILATOR ?= verilator
TOP       ?= tb_user_logic
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  = RESULT: PASS
FAIL_MSG  = RESULT: FAIL
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- jtag_user_pkg.sv
package jtag_user_pkg;

    // One deserialized byte from the host
    localparam int INBOUND_DATA_WIDTH = 8;

    // Received byte counter
    localparam int RESULT_WIDTH = 16;

    // Bypass register of the upstream device in the chain
    localparam int UPSTREAM_BYPASS_BITS = 1;

    // Counter plus valid flag plus alignment flag
    localparam int STATUS_WIDTH = RESULT_WIDTH + 2;

    // Enough bits to index a position inside one byte
    localparam int BIT_COUNT_WIDTH = $clog2(INBOUND_DATA_WIDTH);

    typedef logic [INBOUND_DATA_WIDTH-1:0] inbound_data_t;
    typedef logic [RESULT_WIDTH-1:0]       result_t;
    typedef logic [BIT_COUNT_WIDTH-1:0]    bit_count_t;

    // Bit 0 leaves first on tdo
    //   [0]     outbound_valid
    //   [16:1]  outbound_data
    //   [17]    alignment_error_seen
    typedef logic [STATUS_WIDTH-1:0] status_word_t;

    // Line feed marks the end of a host message
    localparam inbound_data_t TERMINATOR_BYTE = 8'h0A;

    // Decoder FSM
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SKIP,
        DEC_DATA
    } decoder_state_t;

endpackage

//--- src.f
jtag_user_pkg.sv
tap_decoder.sv
tap_encoder.sv
user_logic.sv
user_logic_assertions.sv
tb_user_logic.sv

//--- tap_decoder.sv
module tap_decoder (
    input  logic                         tck,
    input  logic                         tdi,
    input  logic                         test_logic_reset,
    input  logic                         ir_is_user,
    input  logic                         capture_dr,
    input  logic                         shift_dr,
    input  logic                         update_dr,
    output logic                         inbound_valid,
    output jtag_user_pkg::inbound_data_t inbound_data,
    output logic                         inbound_alignment_error
);

    jtag_user_pkg::decoder_state_t state;

    // Position of the next data bit inside the current byte
    jtag_user_pkg::bit_count_t bit_pos;

    // Bypass bits already dropped in this scan
    jtag_user_pkg::bit_count_t skip_cnt;

    jtag_user_pkg::inbound_data_t shreg;
    jtag_user_pkg::inbound_data_t next_shreg;

    logic user_shift;
    logic data_shift;
    logic last_skip;
    logic byte_done;

    assign user_shift = ir_is_user & shift_dr;
    assign data_shift = user_shift && (state == jtag_user_pkg::DEC_DATA);

    assign last_skip = (skip_cnt ==
        jtag_user_pkg::bit_count_t'(jtag_user_pkg::UPSTREAM_BYPASS_BITS - 1));

    assign byte_done = data_shift && (bit_pos ==
        jtag_user_pkg::bit_count_t'(jtag_user_pkg::INBOUND_DATA_WIDTH - 1));

    // LSB first, so new bits enter at the top and move down
    assign next_shreg = {tdi, shreg[jtag_user_pkg::INBOUND_DATA_WIDTH-1:1]};

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            state                   <= jtag_user_pkg::DEC_IDLE;
            bit_pos                 <= '0;
            skip_cnt                <= '0;
            inbound_valid           <= 1'b0;
            inbound_alignment_error <= 1'b0;
        end else begin
            // Both outputs are single-cycle pulses
            inbound_valid           <= 1'b0;
            inbound_alignment_error <= 1'b0;

            if (ir_is_user) begin
                if (capture_dr) begin
                    state    <= jtag_user_pkg::DEC_SKIP;
                    bit_pos  <= '0;
                    skip_cnt <= '0;
                end else if (update_dr) begin
                    // Leftover bits mean the host stopped mid-byte
                    if (state == jtag_user_pkg::DEC_DATA && bit_pos != '0) begin
                        inbound_alignment_error <= 1'b1;
                    end
                    state <= jtag_user_pkg::DEC_IDLE;
                end else if (shift_dr) begin
                    case (state)
                        jtag_user_pkg::DEC_SKIP: begin
                            if (last_skip) begin
                                state <= jtag_user_pkg::DEC_DATA;
                            end else begin
                                skip_cnt <= skip_cnt + 1'b1;
                            end
                        end
                        jtag_user_pkg::DEC_DATA: begin
                            if (byte_done) begin
                                bit_pos       <= '0;
                                inbound_valid <= 1'b1;
                            end else begin
                                bit_pos <= bit_pos + 1'b1;
                            end
                        end
                        default: begin
                            // Shift without a capture is ignored
                        end
                    endcase
                end
            end
        end
    end

    // Payload path
    always_ff @(posedge tck) begin
        if (data_shift) begin
            shreg <= next_shreg;
        end
        if (byte_done) begin
            inbound_data <= next_shreg;
        end
    end

endmodule

//--- tap_encoder.sv
module tap_encoder (
    input  logic                   tck,
    input  logic                   test_logic_reset,
    input  logic                   ir_is_user,
    input  logic                   capture_dr,
    input  logic                   shift_dr,
    input  logic                   outbound_valid,
    input  jtag_user_pkg::result_t outbound_data,
    input  logic                   alignment_error_seen,
    output logic                   tdo
);

    jtag_user_pkg::status_word_t status_q;

    // Falling-edge copy of the outgoing bit
    logic tdo_bit;

    logic user_capture;
    logic user_shift;

    assign user_capture = ir_is_user & capture_dr;
    assign user_shift   = ir_is_user & shift_dr;

    // Load on capture, then walk the word toward bit 0
    // Zeros fill from the top once the status bits are gone
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            status_q <= '0;
        end else if (user_capture) begin
            status_q <= {alignment_error_seen, outbound_data, outbound_valid};
        end else if (user_shift) begin
            status_q <= status_q >> 1;
        end
    end

    // tdo changes half a cycle ahead of the host sampling edge
    always_ff @(negedge tck) begin
        tdo_bit <= status_q[0];
    end

    // Quiet line outside a user shift
    assign tdo = user_shift ? tdo_bit : 1'b0;

endmodule

//--- tb_user_logic.sv
module tb_user_logic;

    localparam int NUM_SCANS = 40;

    // Three whole bytes are enough shifts to read out the full status word
    localparam int MIN_BYTES = 3;
    localparam int MAX_BYTES = 6;

    // Capture, bypass, bytes, partial byte, update, idle gap and a possible reset
    localparam int MAX_SCAN_CYCLES = 1 + jtag_user_pkg::UPSTREAM_BYPASS_BITS
        + MAX_BYTES * jtag_user_pkg::INBOUND_DATA_WIDTH + 7 + 1 + 3 + 3;
    localparam int WATCHDOG_CYCLES = (NUM_SCANS + 2) * MAX_SCAN_CYCLES + 100;

    logic tck;
    logic tdi;
    logic test_logic_reset;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    integer seed = 32'h1fa1;
    int     count_errors;
    int     flag_errors;

    // Reference model state
    jtag_user_pkg::result_t model_count;
    logic                   model_valid;
    logic                   model_align;

    user_logic dut0 (
        .tck              (tck),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .tdo              (tdo)
    );

    initial begin
        tck = 1'b0;
        forever #50 tck = ~tck;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge tck);
        $display("Watchdog expired after %0d cycles, the scans did not complete",
                 WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic int pick(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    task automatic check_count(input string name, input jtag_user_pkg::result_t expected,
                               input jtag_user_pkg::result_t actual);
        if (actual !== expected) begin
            count_errors++;
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(negedge tck);
        test_logic_reset = 1'b1;
        repeat (2) @(negedge tck);
        test_logic_reset = 1'b0;
        model_count = '0;
        model_valid = 1'b0;
        model_align = 1'b0;
    endtask

    // Capture, shift and update; tdo is collected at every rising edge of the shift
    task automatic run_scan(input logic user, input int nbytes, input int extra);
        logic                         bits[$];
        logic                         rx[$];
        jtag_user_pkg::inbound_data_t data_byte;
        jtag_user_pkg::status_word_t  rx_word;
        logic                         saw_term;
        saw_term = 1'b0;
        repeat (jtag_user_pkg::UPSTREAM_BYPASS_BITS) bits.push_back(1'(pick(0, 1)));
        for (int b = 0; b < nbytes; b++) begin
            if (pick(0, 15) == 0) begin
                data_byte = jtag_user_pkg::TERMINATOR_BYTE;
            end else begin
                data_byte = jtag_user_pkg::inbound_data_t'(pick(0, 255));
            end
            if (data_byte == jtag_user_pkg::TERMINATOR_BYTE) begin
                saw_term = 1'b1;
            end
            for (int i = 0; i < jtag_user_pkg::INBOUND_DATA_WIDTH; i++) begin
                bits.push_back(data_byte[i]);
            end
        end
        repeat (extra) bits.push_back(1'(pick(0, 1)));

        @(negedge tck);
        ir_is_user = user;
        capture_dr = 1'b1;
        foreach (bits[k]) begin
            @(negedge tck);
            capture_dr = 1'b0;
            shift_dr   = 1'b1;
            tdi        = bits[k];
            @(posedge tck);
            rx.push_back(tdo);
        end
        @(negedge tck);
        shift_dr  = 1'b0;
        tdi       = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
        repeat (2) @(negedge tck);
        ir_is_user = 1'b1;

        if (user) begin
            rx_word = '0;
            for (int i = 0; i < jtag_user_pkg::STATUS_WIDTH; i++) begin
                rx_word[i] = rx[i];
            end
            check_flag("outbound_valid", model_valid, rx_word[0]);
            check_count("outbound_data", model_count,
                        rx_word[jtag_user_pkg::RESULT_WIDTH:1]);
            check_flag("alignment_error_seen", model_align,
                       rx_word[jtag_user_pkg::STATUS_WIDTH-1]);
            // Zeros follow once the status word has left
            for (int i = jtag_user_pkg::STATUS_WIDTH; i < rx.size(); i++) begin
                check_flag("tdo", 1'b0, rx[i]);
            end
            // Partial byte is dropped but leaves the sticky flag behind
            model_count = model_count + jtag_user_pkg::result_t'(nbytes);
            if (saw_term) begin
                model_valid = 1'b1;
            end
            if (extra != 0) begin
                model_align = 1'b1;
            end
        end else begin
            foreach (rx[i]) begin
                check_flag("tdo", 1'b0, rx[i]);
            end
        end
    endtask

    initial begin
        int mode;
        tdi              = 1'b0;
        test_logic_reset = 1'b1;
        ir_is_user       = 1'b1;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        count_errors     = 0;
        flag_errors      = 0;
        model_count      = '0;
        model_valid      = 1'b0;
        model_align      = 1'b0;
        repeat (2) @(negedge tck);
        test_logic_reset = 1'b0;

        // First read after reset is all zeros
        run_scan(1'b1, MIN_BYTES, 0);
        for (int n = 0; n < NUM_SCANS; n++) begin
            mode = pick(0, 9);
            if (mode == 0) begin
                run_scan(1'b0, pick(MIN_BYTES, MAX_BYTES), 0);
            end else begin
                if (mode == 1) begin
                    apply_reset();
                end
                run_scan(1'b1, pick(MIN_BYTES, MAX_BYTES),
                         (pick(0, 3) == 0) ? pick(1, 7) : 0);
            end
        end
        // Read back the state left by the last scan
        run_scan(1'b1, MIN_BYTES, 0);

        $display("errors: count %0d, flag %0d", count_errors, flag_errors);
        if (count_errors == 0 && flag_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- user_logic.sv
module user_logic (
    input  logic tck,
    input  logic tdi,
    input  logic test_logic_reset,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);

    // Decoder pulses
    logic                         inbound_valid;
    logic                         inbound_alignment_error;
    jtag_user_pkg::inbound_data_t inbound_data;

    // Levels presented to the encoder
    logic                   outbound_valid;
    jtag_user_pkg::result_t outbound_data;
    logic                   alignment_error_seen;

    tap_decoder tap_decoder_i (
        .tck                     (tck),
        .tdi                     (tdi),
        .test_logic_reset        (test_logic_reset),
        .ir_is_user              (ir_is_user),
        .capture_dr              (capture_dr),
        .shift_dr                (shift_dr),
        .update_dr               (update_dr),
        .inbound_valid           (inbound_valid),
        .inbound_data            (inbound_data),
        .inbound_alignment_error (inbound_alignment_error)
    );

    // Byte count wraps at 16 bits
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            outbound_data <= '0;
        end else if (inbound_valid) begin
            outbound_data <= outbound_data + 1'b1;
        end
    end

    // Sticky once a terminator has been seen
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            outbound_valid <= 1'b0;
        end else if (inbound_valid && inbound_data == jtag_user_pkg::TERMINATOR_BYTE) begin
            outbound_valid <= 1'b1;
        end
    end

    // Sticky once any scan ended with a partial byte
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            alignment_error_seen <= 1'b0;
        end else if (inbound_alignment_error) begin
            alignment_error_seen <= 1'b1;
        end
    end

    tap_encoder tap_encoder_i (
        .tck                  (tck),
        .test_logic_reset     (test_logic_reset),
        .ir_is_user           (ir_is_user),
        .capture_dr           (capture_dr),
        .shift_dr             (shift_dr),
        .outbound_valid       (outbound_valid),
        .outbound_data        (outbound_data),
        .alignment_error_seen (alignment_error_seen),
        .tdo                  (tdo)
    );

endmodule

//--- user_logic_assertions.sv
module user_logic_assertions (
    input logic                          tck,
    input logic                          test_logic_reset,
    input logic                          ir_is_user,
    input logic                          shift_dr,
    input logic                          tdo,
    input logic                          inbound_valid,
    input logic                          inbound_alignment_error,
    input logic                          outbound_valid,
    input jtag_user_pkg::result_t        outbound_data,
    input logic                          alignment_error_seen,
    input jtag_user_pkg::decoder_state_t decoder_state
);

    // Line stays quiet outside shift_dr
    quiet_tdo: assert property (@(posedge tck) disable iff (test_logic_reset)
        !shift_dr |-> !tdo)
        else $error("tdo high while shift_dr is low");

    single_valid: assert property (@(posedge tck) disable iff (test_logic_reset)
        inbound_valid |=> !inbound_valid)
        else $error("inbound_valid held for two cycles");

    // Decoder pulses only under the user instruction
    user_only: assert property (@(posedge tck) disable iff (test_logic_reset)
        !ir_is_user |-> !(inbound_valid || inbound_alignment_error))
        else $error("decoder pulse while ir_is_user is low");

    reset_clears: assert property (@(posedge tck)
        test_logic_reset |=> (!tdo && !inbound_valid && !inbound_alignment_error
            && !outbound_valid && outbound_data == '0 && !alignment_error_seen
            && decoder_state == jtag_user_pkg::DEC_IDLE))
        else $error("state not cleared after reset");

endmodule

bind user_logic user_logic_assertions user_logic_assertions_i (
    .tck                     (tck),
    .test_logic_reset        (test_logic_reset),
    .ir_is_user              (ir_is_user),
    .shift_dr                (shift_dr),
    .tdo                     (tdo),
    .inbound_valid           (inbound_valid),
    .inbound_alignment_error (inbound_alignment_error),
    .outbound_valid          (outbound_valid),
    .outbound_data           (outbound_data),
    .alignment_error_seen    (alignment_error_seen),
    .decoder_state           (tap_decoder_i.state)
);
